/* common/core_io_pkg.sv */
package core_io_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and descriptor types
  ////////////////////////////////////////////////////////////

  // One data-bus command from the core
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [1:0]  size;
  } bus_cmd_t;

  // Internal IO write, valid only once the command is accepted
  typedef struct packed {
    logic        valid;
    logic [5:0]  index;
    logic [3:0]  strb;
    logic [31:0] data;
  } io_wr_t;

  // Region enables towards the external memory side
  typedef struct packed {
    logic       dmem_en;
    logic       pmem_en;
    logic       exio_en;
    logic       wen;
    logic [3:0] strb;
  } mem_sel_t;

  // Packet descriptor, type in the top nibble
  typedef struct packed {
    logic [3:0]  desc_type;
    logic [59:0] payload;
  } desc_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Write registers
  localparam logic [5:0] SEND_DESC_L    = 6'd2;
  localparam logic [5:0] SEND_DESC_H    = 6'd3;
  localparam logic [5:0] DRAM_ADDR_L    = 6'd4;
  localparam logic [5:0] DRAM_ADDR_H    = 6'd5;
  localparam logic [5:0] TIMER_STEP     = 6'd7;
  localparam logic [5:0] DRAM_FLAG_WR   = 6'd8;
  localparam logic [5:0] SEND_DESC_TYPE = 6'd10;
  localparam logic [5:0] IN_DESC_STRB   = 6'd11;
  localparam logic [5:0] DRAM_FLAG_CLR  = 6'd12;
  localparam logic [5:0] MASK_WR        = 6'd14;
  localparam logic [5:0] INT_ACK        = 6'd15;

  // Read registers
  localparam logic [5:0] RD_DESC_L      = 6'd32;
  localparam logic [5:0] RD_DESC_H      = 6'd33;
  localparam logic [5:0] RD_DRAM_FLAGS  = 6'd34;
  localparam logic [5:0] RD_STATUS      = 6'd35;
  localparam logic [5:0] RD_CORE_ID     = 6'd36;
  localparam logic [5:0] RD_TIMER_L     = 6'd37;
  localparam logic [5:0] RD_TIMER_H     = 6'd38;
  localparam logic [5:0] RD_INT_FLAGS   = 6'd39;
  localparam logic [5:0] RD_MASK        = 6'd40;

  // Interrupt bit positions in mask, flags and ack data
  localparam int INT_TIMER   = 0;
  localparam int INT_IN_DESC = 1;
  localparam int INT_DRAM    = 2;
  localparam int INT_POKE    = 4;
  localparam int INT_EVICT   = 5;

  localparam logic [15:0] MASK_RESET       = 16'hFFF0;
  localparam logic [31:0] TIMER_STEP_RESET = 32'd1;

endpackage

/* io_regs/desc_out_regs.sv */
`timescale 1ns/1ps

module desc_out_regs (
  input  logic                clk,
  input  logic                rst,
  input  core_io_pkg::io_wr_t io_wr,
  input  logic                out_desc_ready,
  output core_io_pkg::desc_t  out_desc,
  output logic [63:0]         out_desc_dram_addr,
  output logic                out_desc_valid,
  output logic                wr_ready,
  output logic [15:0]         int_mask
);

  logic [63:0] desc_data;
  logic [63:0] dram_addr;
  logic [3:0]  desc_type;
  logic        desc_pending;
  logic        held_index;
  logic        send_desc;

  // Writes that must wait while the consumer still holds the last descriptor
  assign held_index = (io_wr.index == core_io_pkg::SEND_DESC_L)    ||
                      (io_wr.index == core_io_pkg::SEND_DESC_H)    ||
                      (io_wr.index == core_io_pkg::DRAM_ADDR_L)    ||
                      (io_wr.index == core_io_pkg::DRAM_ADDR_H)    ||
                      (io_wr.index == core_io_pkg::SEND_DESC_TYPE);

  assign wr_ready  = !(held_index && desc_pending && !out_desc_ready);
  assign send_desc = io_wr.valid && (io_wr.index == core_io_pkg::SEND_DESC_TYPE);

  // Byte writable payload and DRAM address
  always_ff @(posedge clk) begin
    if (io_wr.valid) begin
      for (int i = 0; i < 4; i++) begin
        if (io_wr.strb[i]) begin
          case (io_wr.index)
            core_io_pkg::SEND_DESC_L: desc_data[i*8 +: 8]    <= io_wr.data[i*8 +: 8];
            core_io_pkg::SEND_DESC_H: desc_data[32+i*8 +: 8] <= io_wr.data[i*8 +: 8];
            core_io_pkg::DRAM_ADDR_L: dram_addr[i*8 +: 8]    <= io_wr.data[i*8 +: 8];
            core_io_pkg::DRAM_ADDR_H: dram_addr[32+i*8 +: 8] <= io_wr.data[i*8 +: 8];
            default: begin
            end
          endcase
        end
      end
    end
    // Type write also launches the descriptor
    if (send_desc) begin
      desc_type <= io_wr.data[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_pending <= 1'b0;
      int_mask     <= core_io_pkg::MASK_RESET;
    end else begin
      if (desc_pending && out_desc_ready) begin
        desc_pending <= 1'b0;
      end
      if (send_desc) begin
        desc_pending <= 1'b1;
      end
      if (io_wr.valid && (io_wr.index == core_io_pkg::MASK_WR)) begin
        int_mask <= io_wr.data[15:0];
      end
    end
  end

  assign out_desc.desc_type = desc_type;
  assign out_desc.payload   = desc_data[59:0];
  assign out_desc_dram_addr = dram_addr;
  assign out_desc_valid     = desc_pending;

endmodule

/* io_regs/dram_recv_flags.sv */
`timescale 1ns/1ps

module dram_recv_flags (
  input  logic                clk,
  input  logic                rst,
  input  core_io_pkg::io_wr_t io_wr,
  input  logic [4:0]          recv_tag,
  input  logic                recv_tag_valid,
  output logic [31:0]         flags,
  output logic                flags_any
);

  logic [4:0] tag_r;
  logic       tag_valid_r;

  // Tag input stage
  always_ff @(posedge clk) begin
    tag_r <= recv_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= 32'd0;
    end else begin
      if (io_wr.valid && (io_wr.index == core_io_pkg::DRAM_FLAG_WR)) begin
        for (int i = 0; i < 4; i++) begin
          if (io_wr.strb[i]) begin
            flags[i*8 +: 8] <= io_wr.data[i*8 +: 8];
          end
        end
      end
      if (io_wr.valid && (io_wr.index == core_io_pkg::DRAM_FLAG_CLR)) begin
        flags[io_wr.data[4:0]] <= 1'b0;
      end
      // An arriving tag beats a clear of the same bit
      if (tag_valid_r) begin
        flags[tag_r] <= 1'b1;
      end
      // Tag 0 is never a valid receive slot
      flags[0] <= 1'b0;
    end
  end

  assign flags_any = |flags;

endmodule

/* io_regs/interval_timer.sv */
`timescale 1ns/1ps

module interval_timer (
  input  logic                clk,
  input  logic                rst,
  input  core_io_pkg::io_wr_t io_wr,
  output logic                timer_flag
);

  logic [31:0] step;
  logic [31:0] count;
  logic        step_wr;
  logic        flag_ack;

  assign step_wr  = io_wr.valid && (io_wr.index == core_io_pkg::TIMER_STEP);
  assign flag_ack = io_wr.valid && (io_wr.index == core_io_pkg::INT_ACK) &&
                    io_wr.data[core_io_pkg::INT_TIMER];

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= core_io_pkg::TIMER_STEP_RESET;
    end else if (step_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (io_wr.strb[i]) begin
          step[i*8 +: 8] <= io_wr.data[i*8 +: 8];
        end
      end
    end
  end

  // Count restarts on a match, flag stays up until acked
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      count      <= 32'd0;
      timer_flag <= 1'b0;
    end else if (count == step) begin
      count      <= 32'd0;
      timer_flag <= 1'b1;
    end else begin
      count <= count + 32'd1;
      if (flag_ack) begin
        timer_flag <= 1'b0;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run the core IO testbench from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_core_io -o sim_core_io
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_core_io)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

/* sources.f */
common/core_io_pkg.sv
io_regs/desc_out_regs.sv
io_regs/interval_timer.sv
io_regs/dram_recv_flags.sv
verilog/bus_decode.sv
verilog/interrupt_ctrl.sv
verilog/io_read_mux.sv
verilog/core_io_top.sv
testbench/io_checker.sv
testbench/tb_core_io.sv

/* testbench/core_io_patterns.txt */
# op name arg0 arg1 expected, numbers in hex
# wr and rd take a register index, mem an address and size, wait/hold/chk a check kind
rd   mask_reset      28      0        fff0
wr   desc_lo         2       89abcdef 0
wr   desc_hi         3       f1234567 0
wr   dram_addr_lo    4       00001000 0
wr   dram_addr_hi    5       00000002 0
wr   desc_type       a       5        0
wait desc_valid      8       a        1
chk  desc_word       1       0        5123456789abcdef
chk  desc_dram_addr  2       0        0000000200001000
hold desc_held       8       6        1
bp   type_stalled    7       5        0
chk  desc_word_2     1       0        7123456789abcdef
set  ready_on        3       1        0
wait desc_consumed   8       a        0
tag  tag_3           3       0        0
tag  tag_0           0       0        0
rd   flags_tag3      22      0        00000008
wr   flag_clr        c       3        0
rd   flags_cleared   22      0        00000000
wr   mask_timer      e       fff1     0
wr   timer_step      7       14       0
wait timer_irq_set   5       28       1
wr   timer_ack       f       1        0
wait timer_irq_clr   5       3        0
wr   timer_park      7       ffffffff 0
wr   mask_restore    e       fff0     0
rd   mask_read       28      0        fff0
set  poke_on         0       1        0
wait ext_irq_set     6       4        1
rd   int_flags_poke  27      0        00000010
wr   poke_ack        f       10       1
set  poke_off        0       0        0
wait ext_irq_clr     6       4        0
wr   evict_ack       f       20       2
mem  dmem_half       800002  1        9c
mem  pmem_byte       1000003 0        58
mem  exio_word       400000  2        3f
set  core_id_set     4       5a       0
rd   core_id_read    24      0        5a
set  in_desc_on      2       1        0
rd   status_read     23      0        101
wr   in_desc_strb    b       1        4
set  in_desc_off     2       0        0

/* testbench/io_checker.sv */
`timescale 1ns/1ps

module io_checker (
  input  logic                  rsp_valid,
  input  logic [31:0]           rsp_data,
  input  core_io_pkg::desc_t    out_desc,
  input  logic [63:0]           out_desc_dram_addr,
  input  logic                  out_desc_valid,
  input  core_io_pkg::mem_sel_t mem_sel,
  input  logic                  cmd_ready,
  input  logic                  in_desc_taken,
  input  logic                  poke_int_ack,
  input  logic                  evict_int_ack,
  input  logic                  ext_irq,
  input  logic                  timer_irq
);

  int pass_count;
  int fail_count;

  initial begin
    pass_count = 0;
    fail_count = 0;
  end

  // Kind codes match the check column of the pattern file
  function automatic logic [63:0] actual_of(input int kind);
    logic [63:0] value;
    case (kind)
      0:       value = {32'd0, rsp_data};
      1:       value = out_desc;
      2:       value = out_desc_dram_addr;
      3:       value = {56'd0, mem_sel};
      4:       value = {61'd0, in_desc_taken, evict_int_ack, poke_int_ack};
      5:       value = {63'd0, timer_irq};
      6:       value = {63'd0, ext_irq};
      7:       value = {63'd0, cmd_ready};
      8:       value = {63'd0, out_desc_valid};
      9:       value = {63'd0, rsp_valid};
      default: value = '1;
    endcase
    return value;
  endfunction

  task automatic record(input logic [159:0] tname, input logic [63:0] exp,
                        input logic [63:0] act);
    if (act === exp) begin
      pass_count++;
      $display("ok  %0s", tname);
    end else begin
      fail_count++;
      $display("ERR %0s expected %h actual %h", tname, exp, act);
    end
  endtask

  task automatic compare(input logic [159:0] tname, input int kind, input logic [63:0] exp);
    record(tname, exp, actual_of(kind));
  endtask

  task automatic note_failure(input logic [159:0] tname, input string msg);
    fail_count++;
    $display("FAIL %0s %0s", tname, msg);
  endtask

  task automatic report();
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
  endtask

endmodule

/* testbench/tb_core_io.sv */
`timescale 1ns/1ps

module tb_core_io;

  localparam int WAIT_LIMIT = 50;

  logic                  clk;
  logic                  rst;
  core_io_pkg::bus_cmd_t cmd;
  logic                  cmd_valid;
  logic                  cmd_ready;
  core_io_pkg::mem_sel_t mem_sel;
  logic                  mem_ready;
  logic [31:0]           mem_rd_data;
  logic                  mem_rd_valid;
  logic                  rsp_valid;
  logic [31:0]           rsp_data;
  core_io_pkg::desc_t    in_desc;
  logic                  in_desc_valid;
  logic                  in_desc_taken;
  core_io_pkg::desc_t    out_desc;
  logic [63:0]           out_desc_dram_addr;
  logic                  out_desc_valid;
  logic                  out_desc_ready;
  logic [4:0]            recv_tag;
  logic                  recv_tag_valid;
  logic                  poke_int;
  logic                  evict_int;
  logic [7:0]            core_id;
  logic [63:0]           timer_ns;
  logic                  ext_irq;
  logic                  timer_irq;
  logic                  poke_int_ack;
  logic                  evict_int_ack;

  // One pattern line
  integer        fd;
  integer        n;
  logic          at_end;
  logic [63:0]   op;
  logic [159:0]  name;
  logic [31:0]   arg0;
  logic [31:0]   arg1;
  logic [63:0]   expected;
  logic [1023:0] skipped;

  core_io_top dut_i (.*);

  io_checker io_checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Bus and input drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_cmd(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] size);
    cmd.wr    <= wr;
    cmd.addr  <= addr;
    cmd.data  <= data;
    cmd.size  <= size;
    cmd_valid <= 1'b1;
  endtask

  task automatic await_accept(output logic taken);
    int cycles;
    taken  = 1'b0;
    cycles = 0;
    while (!taken && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      taken = cmd_ready;
      cycles++;
    end
  endtask

  // Kind below zero skips the check in the accepting cycle
  task automatic send_cmd(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic [1:0] size, input logic [159:0] tname, input int kind,
                          input logic [63:0] exp, output logic taken);
    @(posedge clk);
    drive_cmd(wr, addr, data, size);
    await_accept(taken);
    if (!taken) begin
      io_checker_i.note_failure(tname, "command was never accepted");
    end else if (kind >= 0) begin
      io_checker_i.compare(tname, kind, exp);
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic read_reg(input logic [159:0] tname, input logic [31:0] addr,
                          input logic [63:0] exp);
    logic taken;
    logic seen;
    int   cycles;
    send_cmd(1'b0, addr, 32'd0, 2'd2, tname, -1, 64'd0, taken);
    seen   = 1'b0;
    cycles = 0;
    while (taken && !seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      seen = rsp_valid;
      cycles++;
    end
    if (seen) begin
      io_checker_i.compare(tname, 0, exp);
    end else if (taken) begin
      io_checker_i.note_failure(tname, "no read response");
    end
  endtask

  task automatic wait_for(input logic [159:0] tname, input int kind, input int limit,
                          input logic [63:0] exp);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (io_checker_i.actual_of(kind) !== exp && cycles < limit);
    io_checker_i.compare(tname, kind, exp);
  endtask

  // Value must stay put for the whole window
  task automatic watch_steady(input int kind, input int cycles, input logic [63:0] exp,
                              output logic [63:0] bad);
    logic steady;
    steady = 1'b1;
    bad    = exp;
    repeat (cycles) begin
      @(negedge clk);
      if (steady && io_checker_i.actual_of(kind) !== exp) begin
        steady = 1'b0;
        bad    = io_checker_i.actual_of(kind);
      end
    end
  endtask

  task automatic hold_for(input logic [159:0] tname, input int kind, input int cycles,
                          input logic [63:0] exp);
    logic [63:0] bad;
    watch_steady(kind, cycles, exp, bad);
    io_checker_i.record(tname, exp, bad);
  endtask

  task automatic back_pressure(input logic [159:0] tname, input logic [31:0] type_data,
                               input int cycles, input logic [63:0] exp);
    logic        taken;
    logic [63:0] bad;
    @(posedge clk);
    drive_cmd(1'b1, {24'd0, core_io_pkg::SEND_DESC_TYPE, 2'b00}, type_data, 2'd2);
    watch_steady(7, cycles, exp, bad);
    @(posedge clk);
    out_desc_ready <= 1'b1;
    await_accept(taken);
    @(posedge clk);
    cmd_valid      <= 1'b0;
    out_desc_ready <= 1'b0;
    if (bad !== exp) begin
      io_checker_i.record(tname, exp, bad);
    end else if (!taken) begin
      io_checker_i.note_failure(tname, "held write not accepted after consumer became ready");
    end else begin
      // Second descriptor is pending once the held write goes through
      @(negedge clk);
      io_checker_i.compare(tname, 8, 64'd1);
    end
  endtask

  task automatic apply_setting(input logic [31:0] which, input logic [31:0] value);
    @(posedge clk);
    case (which)
      32'd0:   poke_int <= value[0];
      32'd1:   evict_int <= value[0];
      32'd2:   in_desc_valid <= value[0];
      32'd3:   out_desc_ready <= value[0];
      32'd4:   core_id <= value[7:0];
      default: io_checker_i.note_failure(name, "unknown input in set operation");
    endcase
  endtask

  task automatic inject_tag(input logic [4:0] tag);
    @(posedge clk);
    recv_tag       <= tag;
    recv_tag_valid <= 1'b1;
    @(posedge clk);
    recv_tag_valid <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Pattern dispatch
  ////////////////////////////////////////////////////////////

  task automatic run_op();
    logic [31:0] reg_addr;
    logic        taken;
    reg_addr = {24'd0, arg0[5:0], 2'b00};
    case (op)
      64'("wr"):   send_cmd(1'b1, reg_addr, arg1, 2'd2, name, 4, expected, taken);
      64'("rd"):   read_reg(name, reg_addr, expected);
      64'("mem"):  send_cmd(1'b1, arg0, 32'ha5a5a5a5, arg1[1:0], name, 3, expected, taken);
      64'("wait"): wait_for(name, int'(arg0), int'(arg1), expected);
      64'("hold"): hold_for(name, int'(arg0), int'(arg1), expected);
      64'("bp"):   back_pressure(name, arg0, int'(arg1), expected);
      64'("set"):  apply_setting(arg0, arg1);
      64'("tag"):  inject_tag(arg0[4:0]);
      64'("chk"): begin
        @(negedge clk);
        io_checker_i.compare(name, int'(arg0), expected);
      end
      default:     io_checker_i.note_failure(name, "unknown operation in pattern file");
    endcase
  endtask

  initial begin
    rst            = 1'b1;
    cmd            = '0;
    cmd_valid      = 1'b0;
    mem_ready      = 1'b1;
    mem_rd_data    = 32'd0;
    mem_rd_valid   = 1'b0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_desc_ready = 1'b0;
    recv_tag       = 5'd0;
    recv_tag_valid = 1'b0;
    poke_int       = 1'b0;
    evict_int      = 1'b0;
    core_id        = 8'd0;
    timer_ns       = 64'd0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("testbench/core_io_patterns.txt", "r");
    if (fd == 0) begin
      io_checker_i.note_failure(160'("pattern_file"), "cannot open the pattern file");
    end else begin
      at_end = 1'b0;
      while (!at_end) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) begin
          at_end = 1'b1;
        end else if (op == 64'("#")) begin
          n = $fgets(skipped, fd);
        end else begin
          n = $fscanf(fd, "%s %h %h %h", name, arg0, arg1, expected);
          if (n != 4) begin
            io_checker_i.note_failure(name, "malformed line in pattern file");
            at_end = 1'b1;
          end else begin
            run_op();
          end
        end
      end
      $fclose(fd);
    end

    io_checker_i.report();
    if (io_checker_i.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
  input  core_io_pkg::bus_cmd_t cmd,
  input  logic                  cmd_valid,
  input  logic                  mem_ready,
  input  logic                  wr_ready,
  input  logic                  in_desc_valid,
  output logic                  cmd_ready,
  output core_io_pkg::mem_sel_t mem_sel,
  output core_io_pkg::io_wr_t   io_wr,
  output logic                  io_rd_en,
  output logic [5:0]            io_rd_index,
  output logic                  in_desc_taken
);

  logic       accept;
  logic       internal_io;
  logic       external_io;
  logic       data_mem;
  logic       packet_mem;
  logic       io_wr_req;
  logic [3:0] strb;

  // Region decode on address bits 24 to 22
  assign internal_io = cmd.addr[24:22] == 3'b000;
  assign external_io = cmd.addr[24:22] == 3'b001;
  assign data_mem    = cmd.addr[24:23] == 2'b01;
  assign packet_mem  = cmd.addr[24];

  // Size code to byte strobe
  always_comb begin
    case (cmd.size)
      2'd0:    strb = 4'b0001 << cmd.addr[1:0];
      2'd1:    strb = 4'b0011 << cmd.addr[1:0];
      default: strb = 4'b1111;
    endcase
  end

  assign cmd_ready = mem_ready && wr_ready;
  assign accept    = cmd_valid && cmd_ready;
  assign io_wr_req = cmd_valid && internal_io && cmd.wr;

  assign mem_sel.dmem_en = accept && data_mem;
  assign mem_sel.pmem_en = accept && packet_mem;
  assign mem_sel.exio_en = accept && external_io;
  assign mem_sel.wen     = accept && cmd.wr;
  assign mem_sel.strb    = (accept && cmd.wr) ? strb : 4'b0000;

  // Index reads as the reserved 0 unless an IO write is pending, so the
  // descriptor block can compute wr_ready without looking at acceptance
  assign io_wr.valid = accept && io_wr_req;
  assign io_wr.index = io_wr_req ? cmd.addr[7:2] : 6'd0;
  assign io_wr.strb  = strb;
  assign io_wr.data  = cmd.data;

  assign io_rd_en    = accept && internal_io && !cmd.wr;
  assign io_rd_index = cmd.addr[7:2];

  assign in_desc_taken = io_wr.valid && in_desc_valid &&
                         (io_wr.index == core_io_pkg::IN_DESC_STRB) && cmd.data[0];

endmodule

/* verilog/core_io_top.sv */
`timescale 1ns/1ps

module core_io_top (
  input  logic                  clk,
  input  logic                  rst,

  // Data-bus command from the core
  input  core_io_pkg::bus_cmd_t cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,

  // Memory side
  output core_io_pkg::mem_sel_t mem_sel,
  input  logic                  mem_ready,
  input  logic [31:0]           mem_rd_data,
  input  logic                  mem_rd_valid,

  // Response to the core
  output logic                  rsp_valid,
  output logic [31:0]           rsp_data,

  // Descriptors
  input  core_io_pkg::desc_t    in_desc,
  input  logic                  in_desc_valid,
  output logic                  in_desc_taken,
  output core_io_pkg::desc_t    out_desc,
  output logic [63:0]           out_desc_dram_addr,
  output logic                  out_desc_valid,
  input  logic                  out_desc_ready,

  // Interrupt and status inputs
  input  logic [4:0]            recv_tag,
  input  logic                  recv_tag_valid,
  input  logic                  poke_int,
  input  logic                  evict_int,
  input  logic [7:0]            core_id,
  input  logic [63:0]           timer_ns,

  // Interrupt outputs
  output logic                  ext_irq,
  output logic                  timer_irq,
  output logic                  poke_int_ack,
  output logic                  evict_int_ack
);

  core_io_pkg::io_wr_t io_wr;
  logic                io_rd_en;
  logic [5:0]          io_rd_index;
  logic                wr_ready;
  logic [15:0]         int_mask;
  logic                timer_flag;
  logic [31:0]         flags;
  logic                flags_any;
  logic [31:0]         int_flags;

  bus_decode bus_decode_i (
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .mem_ready     (mem_ready),
    .wr_ready      (wr_ready),
    .in_desc_valid (in_desc_valid),
    .cmd_ready     (cmd_ready),
    .mem_sel       (mem_sel),
    .io_wr         (io_wr),
    .io_rd_en      (io_rd_en),
    .io_rd_index   (io_rd_index),
    .in_desc_taken (in_desc_taken)
  );

  desc_out_regs desc_out_regs_i (
    .clk                (clk),
    .rst                (rst),
    .io_wr              (io_wr),
    .out_desc_ready     (out_desc_ready),
    .out_desc           (out_desc),
    .out_desc_dram_addr (out_desc_dram_addr),
    .out_desc_valid     (out_desc_valid),
    .wr_ready           (wr_ready),
    .int_mask           (int_mask)
  );

  interval_timer interval_timer_i (
    .clk        (clk),
    .rst        (rst),
    .io_wr      (io_wr),
    .timer_flag (timer_flag)
  );

  dram_recv_flags dram_recv_flags_i (
    .clk            (clk),
    .rst            (rst),
    .io_wr          (io_wr),
    .recv_tag       (recv_tag),
    .recv_tag_valid (recv_tag_valid),
    .flags          (flags),
    .flags_any      (flags_any)
  );

  interrupt_ctrl interrupt_ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .io_wr         (io_wr),
    .int_mask      (int_mask),
    .timer_flag    (timer_flag),
    .in_desc_valid (in_desc_valid),
    .flags_any     (flags_any),
    .poke_int      (poke_int),
    .evict_int     (evict_int),
    .ext_irq       (ext_irq),
    .timer_irq     (timer_irq),
    .poke_int_ack  (poke_int_ack),
    .evict_int_ack (evict_int_ack),
    .int_flags     (int_flags)
  );

  io_read_mux io_read_mux_i (
    .clk            (clk),
    .rst            (rst),
    .io_rd_en       (io_rd_en),
    .io_rd_index    (io_rd_index),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .flags          (flags),
    .int_flags      (int_flags),
    .int_mask       (int_mask),
    .core_id        (core_id),
    .timer_ns       (timer_ns),
    .out_desc_ready (out_desc_ready),
    .mem_rd_data    (mem_rd_data),
    .mem_rd_valid   (mem_rd_valid),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data)
  );

endmodule

/* verilog/interrupt_ctrl.sv */
`timescale 1ns/1ps

module interrupt_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  core_io_pkg::io_wr_t io_wr,
  input  logic [15:0]         int_mask,
  input  logic                timer_flag,
  input  logic                in_desc_valid,
  input  logic                flags_any,
  input  logic                poke_int,
  input  logic                evict_int,
  output logic                ext_irq,
  output logic                timer_irq,
  output logic                poke_int_ack,
  output logic                evict_int_ack,
  output logic [31:0]         int_flags
);

  logic int_ack;
  logic any_src;

  assign int_ack = io_wr.valid && (io_wr.index == core_io_pkg::INT_ACK);

  assign any_src = (in_desc_valid && int_mask[core_io_pkg::INT_IN_DESC]) ||
                   (flags_any     && int_mask[core_io_pkg::INT_DRAM])    ||
                   (poke_int      && int_mask[core_io_pkg::INT_POKE])    ||
                   (evict_int     && int_mask[core_io_pkg::INT_EVICT]);

  // Sources stay high until serviced, so one register stage is safe
  // Dropped for a cycle after an ack so the core sees the falling edge
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_irq <= 1'b0;
    end else begin
      ext_irq <= !int_ack && any_src;
    end
  end

  assign timer_irq     = timer_flag && int_mask[core_io_pkg::INT_TIMER];
  assign poke_int_ack  = int_ack && io_wr.data[core_io_pkg::INT_POKE];
  assign evict_int_ack = int_ack && io_wr.data[core_io_pkg::INT_EVICT];

  // Raw flags, not masked
  always_comb begin
    int_flags                           = 32'd0;
    int_flags[core_io_pkg::INT_TIMER]   = timer_flag;
    int_flags[core_io_pkg::INT_IN_DESC] = in_desc_valid;
    int_flags[core_io_pkg::INT_DRAM]    = flags_any;
    int_flags[core_io_pkg::INT_POKE]    = poke_int;
    int_flags[core_io_pkg::INT_EVICT]   = evict_int;
  end

endmodule

/* verilog/io_read_mux.sv */
`timescale 1ns/1ps

module io_read_mux (
  input  logic               clk,
  input  logic               rst,
  input  logic               io_rd_en,
  input  logic [5:0]         io_rd_index,
  input  core_io_pkg::desc_t in_desc,
  input  logic               in_desc_valid,
  input  logic [31:0]        flags,
  input  logic [31:0]        int_flags,
  input  logic [15:0]        int_mask,
  input  logic [7:0]         core_id,
  input  logic [63:0]        timer_ns,
  input  logic               out_desc_ready,
  input  logic [31:0]        mem_rd_data,
  input  logic               mem_rd_valid,
  output logic               rsp_valid,
  output logic [31:0]        rsp_data
);

  logic [31:0] rd_data;
  logic        rd_valid;

  ////////////////////////////////////////////////////////////
  // IO read register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (io_rd_en) begin
      case (io_rd_index)
        core_io_pkg::RD_DESC_L: begin
          if (in_desc_valid) begin
            rd_data <= in_desc[31:0];
          end
        end
        core_io_pkg::RD_DESC_H: begin
          if (in_desc_valid) begin
            rd_data <= in_desc[63:32];
          end
        end
        core_io_pkg::RD_DRAM_FLAGS: rd_data <= flags;
        core_io_pkg::RD_STATUS:     rd_data <= {23'd0, out_desc_ready, 7'd0, in_desc_valid};
        core_io_pkg::RD_CORE_ID:    rd_data <= {24'd0, core_id};
        core_io_pkg::RD_TIMER_L:    rd_data <= timer_ns[31:0];
        core_io_pkg::RD_TIMER_H:    rd_data <= timer_ns[63:32];
        core_io_pkg::RD_INT_FLAGS:  rd_data <= int_flags;
        core_io_pkg::RD_MASK:       rd_data <= {16'd0, int_mask};
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= io_rd_en;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response to the core
  ////////////////////////////////////////////////////////////

  assign rsp_valid = rd_valid || mem_rd_valid;
  assign rsp_data  = rd_valid ? rd_data : mem_rd_data;

endmodule
